// ==== common/trap_settings.svh ====
// Build-time settings for the machine-mode trap and CSR block.
`ifndef TRAP_SETTINGS_SVH
`define TRAP_SETTINGS_SVH

// Register and data width.
`define TRAP_XLEN           32

// Lowest external interrupt number, the external lines sit above it in mip.
`define TRAP_IRQ_LO         16

// Machine timer interrupt bit.
`define TRAP_TIMER_IRQ      7

// Cycles mstatus.MIE has to stay set before interrupts are taken.
`define TRAP_MIE_SETTLE     2

// Constant ID registers.
`define TRAP_MARCHID        32'd37
`define TRAP_HARTID         32'd0
// Major version 2, divider latency 2 in bits 21:16.
`define TRAP_MIMPID         32'h0002_0200

// RV32 with A, C, I and M.
`define TRAP_MISA           32'h4000_1105

// mstatus after reset, MPP is machine.
`define TRAP_MSTATUS_RESET  32'h0000_1800

`endif

// ==== common/trap_pkg.sv ====
// Types shared by the trap and CSR block and its testbench.
`include "trap_settings.svh"

package trap_pkg;

    // Width of a trap or interrupt cause code.
    localparam int CAUSE_W = 5;

    // Implemented machine CSR addresses.
    typedef enum logic [11:0] {
        CSR_MSTATUS    = 12'h300,
        CSR_MISA       = 12'h301,
        CSR_MEDELEG    = 12'h302,
        CSR_MIDELEG    = 12'h303,
        CSR_MIE        = 12'h304,
        CSR_MTVEC      = 12'h305,
        CSR_MSTATUSH   = 12'h310,
        CSR_MSCRATCH   = 12'h340,
        CSR_MEPC       = 12'h341,
        CSR_MCAUSE     = 12'h342,
        CSR_MTVAL      = 12'h343,
        CSR_MIP        = 12'h344,
        CSR_MVENDORID  = 12'hf11,
        CSR_MARCHID    = 12'hf12,
        CSR_MIMPID     = 12'hf13,
        CSR_MHARTID    = 12'hf14,
        CSR_MCONFIGPTR = 12'hf15
    } csr_addr_e;

    // Synchronous exception causes.
    typedef enum logic [CAUSE_W-1:0] {
        ECAUSE_IALIGN   = 5'd0,
        ECAUSE_IACCESS  = 5'd1,
        ECAUSE_IILLEGAL = 5'd2,
        ECAUSE_EBREAK   = 5'd3,
        ECAUSE_LALIGN   = 5'd4,
        ECAUSE_LACCESS  = 5'd5,
        ECAUSE_SALIGN   = 5'd6,
        ECAUSE_SACCESS  = 5'd7,
        ECAUSE_U_ECALL  = 5'd8,
        ECAUSE_S_ECALL  = 5'd9,
        ECAUSE_M_ECALL  = 5'd11,
        ECAUSE_IPAGE    = 5'd12,
        ECAUSE_LPAGE    = 5'd13,
        ECAUSE_SPAGE    = 5'd15
    } ecause_e;

    // Privilege levels.
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    // Kind of event handled in a cycle.
    typedef enum logic [1:0] {
        EVT_NONE,
        EVT_EXC,
        EVT_IRQ,
        EVT_RET
    } evt_kind_e;

    // CSR access from the core.
    typedef struct packed {
        logic                  we;
        csr_addr_e             addr;
        logic [`TRAP_XLEN-1:0] wdata;
    } csr_req_t;

    // CSR read result.
    typedef struct packed {
        logic [`TRAP_XLEN-1:0] rdata;
        logic                  exists;
        logic                  rdonly;
    } csr_rsp_t;

    // Retiring instruction.
    typedef struct packed {
        logic                  valid;
        logic                  trap;
        ecause_e               cause;
        logic [`TRAP_XLEN-1:1] pc;
        logic [`TRAP_XLEN-1:0] insn;
        logic [`TRAP_XLEN-1:0] vaddr;
    } retire_t;

    // Event applied to the CSRs.
    typedef struct packed {
        evt_kind_e             kind;
        logic [CAUSE_W-1:0]    cause;
        logic [`TRAP_XLEN-1:1] epc;
        logic [`TRAP_XLEN-1:0] tval;
    } trap_evt_t;

    // Redirect to the trap vector.
    typedef struct packed {
        logic                  irq;
        logic                  exc;
        logic [CAUSE_W-1:0]    cause;
        logic [`TRAP_XLEN-1:0] vec;
    } take_t;

    // Snapshot of the writable machine CSRs.
    typedef struct packed {
        logic                  mstatus_mie;
        logic                  mstatus_mpie;
        priv_e                 mstatus_mpp;
        logic [`TRAP_XLEN-1:0] mie;
        logic [`TRAP_XLEN-1:2] mtvec;
        logic [`TRAP_XLEN-1:0] mscratch;
        logic [`TRAP_XLEN-1:1] mepc;
        logic                  mcause_int;
        logic [CAUSE_W-1:0]    mcause_no;
        logic [`TRAP_XLEN-1:0] mtval;
    } csr_state_t;

endpackage

// ==== rtl/irq_arbiter.sv ====
// Interrupt arbiter that latches the lines and picks the lowest enabled cause.
`timescale 1ns/1ps
`include "trap_settings.svh"

module irq_arbiter (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic [`TRAP_XLEN-`TRAP_IRQ_LO-1:0]             irq,
    input  logic                                           timer_irq,
    input  trap_pkg::csr_state_t                           state,
    output logic [`TRAP_XLEN-1:0]                          mip,
    output logic                                           irq_pending,
    output logic [trap_pkg::CAUSE_W-1:0]                   irq_cause
);
    import trap_pkg::*;

    // Lines placed at their mip positions.
    logic [`TRAP_XLEN-1:0]       mip_next;
    // Pending and enabled.
    logic [`TRAP_XLEN-1:0]       irq_mask;
    // History of mstatus.MIE.
    logic [`TRAP_MIE_SETTLE-1:0] mie_hist;
    logic                        irq_en;

    always_comb begin
        mip_next = '0;
        mip_next[`TRAP_XLEN-1:`TRAP_IRQ_LO] = irq;
        mip_next[`TRAP_TIMER_IRQ] = timer_irq;
    end

    // One register stage before the lines show in mip.
    always_ff @(posedge clk) begin
        if (rst) begin
            mip <= '0;
        end else begin
            mip <= mip_next;
        end
    end

    assign irq_mask = mip & state.mie;

    // Scan downwards so the lowest set bit is the last one written.
    always_comb begin
        irq_cause = '0;
        for (int i = `TRAP_XLEN - 1; i >= 0; i--) begin
            if (irq_mask[i]) begin
                irq_cause = CAUSE_W'(i);
            end
        end
    end

    // MIE must have been seen set for the whole settle window.
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist <= {mie_hist[`TRAP_MIE_SETTLE-2:0], state.mstatus_mie};
        end
    end

    assign irq_en      = (&mie_hist) && state.mstatus_mie;
    assign irq_pending = (|irq_mask) && irq_en;

endmodule

// ==== rtl/trap_dispatch.sv ====
// Trap dispatcher that picks interrupt, exception or return and tracks privilege.
`timescale 1ns/1ps
`include "trap_settings.svh"

module trap_dispatch (
    input  logic                         clk,
    input  logic                         rst,
    input  trap_pkg::retire_t            retire,
    input  logic                         mret,
    input  logic                         irq_pending,
    input  logic [trap_pkg::CAUSE_W-1:0] irq_cause,
    input  trap_pkg::csr_state_t         state,
    output trap_pkg::trap_evt_t          evt,
    output trap_pkg::take_t              take,
    output logic [`TRAP_XLEN-1:1]        ret_epc,
    output trap_pkg::priv_e              cur_priv
);
    import trap_pkg::*;

    // Value for mtval, chosen by exception cause.
    logic [`TRAP_XLEN-1:0] exc_tval;

    always_comb begin
        case (retire.cause)
            ECAUSE_IALIGN, ECAUSE_IACCESS, ECAUSE_IPAGE: exc_tval = {retire.pc, 1'b0};
            ECAUSE_IILLEGAL: exc_tval = retire.insn;
            ECAUSE_LALIGN, ECAUSE_LACCESS, ECAUSE_LPAGE,
            ECAUSE_SALIGN, ECAUSE_SACCESS, ECAUSE_SPAGE: exc_tval = retire.vaddr;
            default: exc_tval = '0;
        endcase
    end

    // Interrupt first, then exception, then return.
    always_comb begin
        evt       = '0;
        evt.kind  = EVT_NONE;
        evt.epc   = retire.pc;
        if (irq_pending && retire.valid) begin
            evt.kind  = EVT_IRQ;
            evt.cause = irq_cause;
        end else if (retire.trap) begin
            evt.kind  = EVT_EXC;
            evt.cause = retire.cause;
            evt.tval  = exc_tval;
        end else if (mret) begin
            evt.kind  = EVT_RET;
        end
    end

    assign take.irq   = (evt.kind == EVT_IRQ);
    assign take.exc   = (evt.kind == EVT_EXC);
    assign take.cause = evt.cause;
    // Direct mode only.
    assign take.vec   = {state.mtvec, 2'b00};

    assign ret_epc = state.mepc;

    // Traps enter machine mode, MRET goes back to MPP.
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_priv <= PRIV_M;
        end else if (evt.kind == EVT_IRQ || evt.kind == EVT_EXC) begin
            cur_priv <= PRIV_M;
        end else if (evt.kind == EVT_RET) begin
            cur_priv <= state.mstatus_mpp;
        end
    end

endmodule

// ==== csr/csr_file.sv ====
// Machine CSR storage, updated by traps, returns and CSR writes.
`timescale 1ns/1ps
`include "trap_settings.svh"

module csr_file (
    input  logic                 clk,
    input  logic                 rst,
    input  trap_pkg::csr_req_t   csr_req,
    input  trap_pkg::trap_evt_t  evt,
    input  trap_pkg::priv_e      cur_priv,
    output trap_pkg::csr_state_t state
);
    import trap_pkg::*;

    // Reset image of mstatus.
    localparam logic [`TRAP_XLEN-1:0] MSTATUS_RST = `TRAP_MSTATUS_RESET;

    // Trap or interrupt taken this cycle.
    logic trap_take;
    // MPP value legalised from the write data.
    priv_e wr_mpp;

    assign trap_take = (evt.kind == EVT_EXC) || (evt.kind == EVT_IRQ);

    // Anything other than 0 selects machine.
    assign wr_mpp = (csr_req.wdata[12:11] != 2'b00) ? PRIV_M : PRIV_U;

    always_ff @(posedge clk) begin
        if (rst) begin
            state.mstatus_mie  <= MSTATUS_RST[3];
            state.mstatus_mpie <= MSTATUS_RST[7];
            state.mstatus_mpp  <= priv_e'(MSTATUS_RST[12:11]);
            state.mie          <= '0;
            state.mtvec        <= '0;
            state.mscratch     <= '0;
            state.mepc         <= '0;
            state.mcause_int   <= 1'b0;
            state.mcause_no    <= '0;
            state.mtval        <= '0;

        end else if (trap_take) begin
            // Save context and disable interrupts.
            state.mstatus_mpie <= state.mstatus_mie;
            state.mstatus_mie  <= 1'b0;
            state.mstatus_mpp  <= cur_priv;
            state.mcause_int   <= (evt.kind == EVT_IRQ);
            state.mcause_no    <= evt.cause;
            state.mepc         <= evt.epc;
            state.mtval        <= evt.tval;

        end else if (evt.kind == EVT_RET) begin
            // Restore the interrupt enable.
            state.mstatus_mie  <= state.mstatus_mpie;

        end else if (csr_req.we) begin
            // Plain CSR write.
            case (csr_req.addr)
                CSR_MSTATUS: begin
                    state.mstatus_mie  <= csr_req.wdata[3];
                    state.mstatus_mpie <= csr_req.wdata[7];
                    state.mstatus_mpp  <= wr_mpp;
                end
                CSR_MIE: begin
                    state.mie <= csr_req.wdata;
                end
                CSR_MTVEC: begin
                    // Vector is word aligned, direct mode.
                    state.mtvec <= csr_req.wdata[`TRAP_XLEN-1:2];
                end
                CSR_MSCRATCH: begin
                    state.mscratch <= csr_req.wdata;
                end
                CSR_MEPC: begin
                    state.mepc <= csr_req.wdata[`TRAP_XLEN-1:1];
                end
                CSR_MCAUSE: begin
                    state.mcause_int <= csr_req.wdata[`TRAP_XLEN-1];
                    state.mcause_no  <= csr_req.wdata[CAUSE_W-1:0];
                end
                CSR_MTVAL: begin
                    state.mtval <= csr_req.wdata;
                end
                default: begin
                    // Read-only or hardwired, write is dropped.
                end
            endcase
        end
    end

endmodule

// ==== csr/csr_read_mux.sv ====
// CSR read decoder giving data, existence and read-only flag per address.
`timescale 1ns/1ps
`include "trap_settings.svh"

module csr_read_mux (
    input  trap_pkg::csr_addr_e   csr_addr,
    input  trap_pkg::csr_state_t  state,
    input  logic [`TRAP_XLEN-1:0] mip,
    output trap_pkg::csr_rsp_t    csr_rsp
);
    import trap_pkg::*;

    // mstatus built from its fields.
    logic [`TRAP_XLEN-1:0] mstatus;
    // mcause built from its fields.
    logic [`TRAP_XLEN-1:0] mcause;

    always_comb begin
        mstatus        = '0;
        mstatus[3]     = state.mstatus_mie;
        mstatus[7]     = state.mstatus_mpie;
        mstatus[12:11] = state.mstatus_mpp;
    end

    always_comb begin
        mcause                 = '0;
        mcause[`TRAP_XLEN-1]   = state.mcause_int;
        mcause[CAUSE_W-1:0]    = state.mcause_no;
    end

    always_comb begin
        csr_rsp        = '0;
        csr_rsp.exists = 1'b1;
        case (csr_addr)
            CSR_MSTATUS:  csr_rsp.rdata = mstatus;
            // Constant, writes are ignored.
            CSR_MISA:     csr_rsp.rdata = `TRAP_MISA;
            // No delegation without S-mode.
            CSR_MEDELEG:  csr_rsp.rdata = '0;
            CSR_MIDELEG:  csr_rsp.rdata = '0;
            CSR_MIE:      csr_rsp.rdata = state.mie;
            CSR_MTVEC:    csr_rsp.rdata = {state.mtvec, 2'b00};
            CSR_MSTATUSH: csr_rsp.rdata = '0;
            CSR_MSCRATCH: csr_rsp.rdata = state.mscratch;
            CSR_MEPC:     csr_rsp.rdata = {state.mepc, 1'b0};
            CSR_MCAUSE:   csr_rsp.rdata = mcause;
            CSR_MTVAL:    csr_rsp.rdata = state.mtval;
            CSR_MIP:      csr_rsp.rdata = mip;
            // ID registers.
            CSR_MVENDORID: begin
                csr_rsp.rdata  = '0;
                csr_rsp.rdonly = 1'b1;
            end
            CSR_MARCHID: begin
                csr_rsp.rdata  = `TRAP_MARCHID;
                csr_rsp.rdonly = 1'b1;
            end
            CSR_MIMPID: begin
                csr_rsp.rdata  = `TRAP_MIMPID;
                csr_rsp.rdonly = 1'b1;
            end
            CSR_MHARTID: begin
                csr_rsp.rdata  = `TRAP_HARTID;
                csr_rsp.rdonly = 1'b1;
            end
            CSR_MCONFIGPTR: begin
                csr_rsp.rdata  = '0;
                csr_rsp.rdonly = 1'b1;
            end
            default: begin
                // Not implemented.
                csr_rsp.exists = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/trap_unit.sv ====
// Machine-mode trap and CSR block top level.
`timescale 1ns/1ps
`include "trap_settings.svh"

module trap_unit (
    input  logic                                   clk,
    input  logic                                   rst,
    input  trap_pkg::csr_req_t                     csr_req,
    output trap_pkg::csr_rsp_t                     csr_rsp,
    input  trap_pkg::retire_t                      retire,
    input  logic                                   mret,
    input  logic [`TRAP_XLEN-`TRAP_IRQ_LO-1:0]     irq,
    input  logic                                   timer_irq,
    output trap_pkg::take_t                        take,
    output logic [`TRAP_XLEN-1:1]                  ret_epc,
    output trap_pkg::priv_e                        cur_priv
);
    import trap_pkg::*;

    // Latched interrupt lines.
    logic [`TRAP_XLEN-1:0] mip;
    logic                  irq_pending;
    logic [CAUSE_W-1:0]    irq_cause;
    // Event of this cycle.
    trap_evt_t             evt;
    // CSR register snapshot.
    csr_state_t            state;

    irq_arbiter irq_arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .irq         (irq),
        .timer_irq   (timer_irq),
        .state       (state),
        .mip         (mip),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause)
    );

    trap_dispatch trap_dispatch_i (
        .clk         (clk),
        .rst         (rst),
        .retire      (retire),
        .mret        (mret),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause),
        .state       (state),
        .evt         (evt),
        .take        (take),
        .ret_epc     (ret_epc),
        .cur_priv    (cur_priv)
    );

    csr_file csr_file_i (
        .clk      (clk),
        .rst      (rst),
        .csr_req  (csr_req),
        .evt      (evt),
        .cur_priv (cur_priv),
        .state    (state)
    );

    csr_read_mux csr_read_mux_i (
        .csr_addr (csr_req.addr),
        .state    (state),
        .mip      (mip),
        .csr_rsp  (csr_rsp)
    );

endmodule

// ==== tests/trap_unit_assertions.sv ====
// Concurrent checks on the trap flags and privilege at the trap unit ports.
`timescale 1ns/1ps

module trap_unit_assertions (
    input  logic              clk,
    input  logic              rst,
    input  trap_pkg::take_t   take,
    input  trap_pkg::priv_e   cur_priv
);
    import trap_pkg::*;

    // Number of assertion failures so far.
    int fail_count = 0;

    // Interrupt and exception are exclusive.
    property take_exclusive;
        @(posedge clk) disable iff (rst) !(take.irq && take.exc);
    endproperty

    // Any trap lands in machine mode.
    property priv_after_take;
        @(posedge clk) disable iff (rst) (take.irq || take.exc) |=> (cur_priv == PRIV_M);
    endproperty

    // Quiet while in reset.
    property no_take_in_reset;
        @(posedge clk) rst |-> !(take.irq || take.exc);
    endproperty

    take_exclusive_a: assert property (take_exclusive)
        else begin
            $error("irq and exc both set");
            fail_count++;
        end

    priv_after_take_a: assert property (priv_after_take)
        else begin
            $error("priv not M after trap");
            fail_count++;
        end

    no_take_in_reset_a: assert property (no_take_in_reset)
        else begin
            $error("trap taken in reset");
            fail_count++;
        end

endmodule

bind trap_unit trap_unit_assertions trap_unit_assertions_i (
    .clk      (clk),
    .rst      (rst),
    .take     (take),
    .cur_priv (cur_priv)
);

// ==== tests/trap_unit_tb.sv ====
// Directed testbench for the machine-mode trap and CSR block.
`timescale 1ns/1ps
`include "trap_settings.svh"

module trap_unit_tb;
    import trap_pkg::*;

    // Inputs change this long after the rising edge.
    localparam int DRIVE_DELAY = 1;
    localparam int IRQ_TIMEOUT = 20;

    logic          clk;
    logic          rst;
    csr_req_t      csr_req;
    csr_rsp_t      csr_rsp;
    retire_t       retire;
    logic          mret;
    logic [15:0]   irq;
    logic          timer_irq;
    take_t         take;
    logic [31:1]   ret_epc;
    priv_e         cur_priv;

    int            mismatches;
    int            timeouts;
    int            assert_fails;
    logic [31:0]   lfsr;
    // Values the later tests expect back.
    logic [31:0]   mtvec_val;
    logic [31:0]   mepc_val;

    trap_unit trap_unit_i (
        .clk       (clk),
        .rst       (rst),
        .csr_req   (csr_req),
        .csr_rsp   (csr_rsp),
        .retire    (retire),
        .mret      (mret),
        .irq       (irq),
        .timer_irq (timer_irq),
        .take      (take),
        .ret_epc   (ret_epc),
        .cur_priv  (cur_priv)
    );

    always #50 clk = ~clk;

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit of the word.
    task automatic next_random(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        mismatches++;
        $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    endtask

    // Write lands on the next edge.
    task automatic csr_write(input csr_addr_e addr, input logic [31:0] data);
        csr_req.we    = 1'b1;
        csr_req.addr  = addr;
        csr_req.wdata = data;
        next_cycle();
        csr_req.we    = 1'b0;
    endtask

    // Response sampled mid-cycle.
    task automatic csr_read(input csr_addr_e addr, output csr_rsp_t rsp);
        csr_req.we   = 1'b0;
        csr_req.addr = addr;
        @(negedge clk);
        rsp = csr_rsp;
        next_cycle();
    endtask

    task automatic reset_values;
        csr_rsp_t rsp;
        @(negedge clk);
        if (take.irq || take.exc) report_mismatch("take.irq|exc", {take.irq, take.exc}, 0);
        if (cur_priv != PRIV_M) report_mismatch("cur_priv", cur_priv, PRIV_M);
        next_cycle();
        csr_read(CSR_MSTATUS, rsp);
        if (rsp.rdata != `TRAP_MSTATUS_RESET) report_mismatch("mstatus", rsp.rdata, 32'h1800);
        csr_read(CSR_MSCRATCH, rsp);
        if (rsp.rdata != 32'h0) report_mismatch("mscratch", rsp.rdata, 32'h0);
        csr_read(CSR_MARCHID, rsp);
        if (rsp.rdata != 32'd37) report_mismatch("marchid", rsp.rdata, 32'd37);
        if (!rsp.rdonly) report_mismatch("marchid.rdonly", rsp.rdonly, 1);
        csr_read(CSR_MISA, rsp);
        if (rsp.rdata != `TRAP_MISA) report_mismatch("misa", rsp.rdata, `TRAP_MISA);
        // No CSR at 0x7c0.
        csr_read(csr_addr_e'(12'h7c0), rsp);
        if (rsp.exists) report_mismatch("csr 0x7c0 exists", rsp.exists, 0);
    endtask

    task automatic round_trip_writes;
        csr_rsp_t    rsp;
        logic [31:0] w;
        for (int n = 0; n < 4; n++) begin
            next_random(w);
            csr_write(CSR_MSCRATCH, w);
            csr_read(CSR_MSCRATCH, rsp);
            if (rsp.rdata != w) report_mismatch("mscratch", rsp.rdata, w);
        end
        next_random(w);
        mtvec_val = w & 32'hffff_fffc;
        csr_write(CSR_MTVEC, w);
        csr_read(CSR_MTVEC, rsp);
        if (rsp.rdata != mtvec_val) report_mismatch("mtvec", rsp.rdata, mtvec_val);
        next_random(w);
        csr_write(CSR_MEPC, w);
        csr_read(CSR_MEPC, rsp);
        if (rsp.rdata != (w & 32'hffff_fffe)) report_mismatch("mepc", rsp.rdata, w & ~32'h1);
    endtask

    task automatic illegal_insn_trap;
        csr_rsp_t    rsp;
        logic [31:0] pc;
        logic [31:0] insn;
        next_random(pc);
        next_random(insn);
        // MIE on with MPP machine.
        csr_write(CSR_MSTATUS, 32'h0000_1808);
        retire       = '0;
        retire.valid = 1'b1;
        retire.trap  = 1'b1;
        retire.cause = ECAUSE_IILLEGAL;
        retire.pc    = pc[31:1];
        retire.insn  = insn;
        @(negedge clk);
        if (!take.exc) report_mismatch("take.exc", take.exc, 1);
        if (take.vec != mtvec_val) report_mismatch("take.vec", take.vec, mtvec_val);
        next_cycle();
        retire = '0;
        csr_read(CSR_MEPC, rsp);
        if (rsp.rdata != {pc[31:1], 1'b0}) report_mismatch("mepc", rsp.rdata, pc & ~32'h1);
        csr_read(CSR_MCAUSE, rsp);
        if (rsp.rdata != 32'd2) report_mismatch("mcause", rsp.rdata, 32'd2);
        csr_read(CSR_MTVAL, rsp);
        if (rsp.rdata != insn) report_mismatch("mtval", rsp.rdata, insn);
        // MIE cleared and MPIE taken from the old MIE, MPP stays machine.
        csr_read(CSR_MSTATUS, rsp);
        if (rsp.rdata != 32'h0000_1880) report_mismatch("mstatus", rsp.rdata, 32'h1880);
    endtask

    task automatic irq_priority;
        csr_rsp_t    rsp;
        logic [31:0] pc;
        logic        seen;
        logic [4:0]  got_cause;
        seen      = 1'b0;
        got_cause = '0;
        next_random(pc);
        csr_write(CSR_MIE, 32'h0011_0000);
        csr_write(CSR_MSTATUS, 32'h0000_1808);
        // Lines 16 and 20.
        irq          = 16'h0011;
        retire       = '0;
        retire.valid = 1'b1;
        retire.pc    = pc[31:1];
        for (int n = 0; n < IRQ_TIMEOUT && !seen; n++) begin
            @(negedge clk);
            if (take.irq) begin
                seen      = 1'b1;
                got_cause = take.cause;
            end
            next_cycle();
        end
        retire = '0;
        irq    = '0;
        if (!seen) begin
            timeouts++;
            $display("timed out waiting for the interrupt flag");
        end else begin
            if (got_cause != 5'd16) report_mismatch("take.cause", got_cause, 16);
            csr_read(CSR_MCAUSE, rsp);
            if (rsp.rdata != 32'h8000_0010) report_mismatch("mcause", rsp.rdata, 32'h8000_0010);
        end
        mepc_val = {pc[31:1], 1'b0};
    endtask

    task automatic mret_privilege;
        csr_rsp_t    rsp;
        logic [31:0] pc;
        next_random(pc);
        // MPIE set and MPP user.
        csr_write(CSR_MSTATUS, 32'h0000_0080);
        csr_write(CSR_MEPC, mepc_val);
        mret = 1'b1;
        @(negedge clk);
        if (ret_epc != mepc_val[31:1]) report_mismatch("ret_epc", {ret_epc, 1'b0}, mepc_val);
        next_cycle();
        mret = 1'b0;
        @(negedge clk);
        if (cur_priv != PRIV_U) report_mismatch("cur_priv", cur_priv, PRIV_U);
        next_cycle();
        csr_read(CSR_MSTATUS, rsp);
        if (!rsp.rdata[3]) report_mismatch("mstatus.mie", rsp.rdata[3], 1);
        retire       = '0;
        retire.valid = 1'b1;
        retire.trap  = 1'b1;
        retire.cause = ECAUSE_U_ECALL;
        retire.pc    = pc[31:1];
        @(negedge clk);
        if (!take.exc) report_mismatch("take.exc", take.exc, 1);
        next_cycle();
        retire = '0;
        @(negedge clk);
        if (cur_priv != PRIV_M) report_mismatch("cur_priv", cur_priv, PRIV_M);
        next_cycle();
        // MPP records user mode.
        csr_read(CSR_MSTATUS, rsp);
        if (rsp.rdata != 32'h0000_0080) report_mismatch("mstatus", rsp.rdata, 32'h0080);
        csr_read(CSR_MCAUSE, rsp);
        if (rsp.rdata != 32'd8) report_mismatch("mcause", rsp.rdata, 32'd8);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        csr_req      = '0;
        retire       = '0;
        mret         = 1'b0;
        irq          = '0;
        timer_irq    = 1'b0;
        mismatches   = 0;
        timeouts     = 0;
        assert_fails = 0;
        mtvec_val    = '0;
        mepc_val     = '0;
        lfsr         = 32'h76d2_1dc6;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        reset_values();
        round_trip_writes();
        illegal_insn_trap();
        irq_priority();
        mret_privilege();
        assert_fails = trap_unit_i.trap_unit_assertions_i.fail_count;
        $display("mismatches: %0d, timeouts: %0d, assertion failures: %0d",
                 mismatches, timeouts, assert_fails);
        if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+common
common/trap_pkg.sv
rtl/irq_arbiter.sv
rtl/trap_dispatch.sv
csr/csr_file.sv
csr/csr_read_mux.sv
rtl/trap_unit.sv
tests/trap_unit_assertions.sv
tests/trap_unit_tb.sv
